//--- sim.f
+incdir+.
alu_pipe_pkg.sv
pipe_ifs.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
alu_pipe_top.sv
tb_alu_pipe.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_alu_pipe \
    -Mdir obj_dir -o tb_alu_pipe
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_alu_pipe > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" sim.log; then
    exit 0
fi
exit 1

//--- tb_alu_pipe.sv
`timescale 1ns/1ns
`default_nettype none
`include "alu_pipe_defines.svh"

module tb_alu_pipe;

    localparam int NUM_INSTS    = 400;
    localparam int RESET_CYCLES = 8;
    localparam int CLK_PERIOD   = 40;

    typedef struct {
        int          due;  // cycle in which the write-back must show
        logic        we;
        logic        ri;
        logic [4:0]  addr;
        logic [31:0] data;
        string       name;
    } wb_exp_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        inst_valid;
    logic [31:0] inst;
    logic        wb_valid;
    logic        wb_we;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        wb_ri;

    integer      seed;
    int          cycle;
    int          value_errors;
    int          flow_errors;
    logic [31:0] model_regs [32];
    wb_exp_t     pending [$];

    alu_pipe_top dut0 (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .wb_valid   (wb_valid),
        .wb_we      (wb_we),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .wb_ri      (wb_ri)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    task automatic check_field(input string test, input string field,
                               input logic [31:0] exp_v, input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            value_errors++;
            $display("FAILED %s %s: expected %h, actual %h", test, field, exp_v, act_v);
        end
    endtask

    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = $random(seed);
        if (r[3:0] < 4'd12) return {2'b00, r[6:4]};  // mostly r0..r7 for more hazards
        return r[8:4];
    endfunction

    task automatic issue_kept(input int n);
        int          kind;
        logic [4:0]  rs, rt, rd, sa, dest;
        logic [15:0] imm;
        logic [31:0] a, b, simm, zimm, res;
        logic [5:0]  code;
        string       mnem;
        kind = int'($unsigned($random(seed)) % 21);
        rs   = pick_reg();
        rt   = pick_reg();
        rd   = pick_reg();
        sa   = 5'($random(seed));
        imm  = 16'($random(seed));
        if (kind >= 8 && kind <= 10) rs = 5'd0;  // shifts by sa
        else if (kind < 14) sa = 5'd0;
        if (kind == 20) rs = 5'd0;               // lui
        a    = model_regs[rs];
        b    = model_regs[rt];
        simm = {{16{imm[15]}}, imm};
        zimm = {16'h0000, imm};
        case (kind)
            0:  begin mnem = "addu";  code = `ALU_PIPE_FN_ADDU;    res = a + b;  end
            1:  begin mnem = "subu";  code = `ALU_PIPE_FN_SUBU;    res = a - b;  end
            2:  begin mnem = "slt";   code = `ALU_PIPE_FN_SLT;
                      res = {31'b0, $signed(a) < $signed(b)}; end
            3:  begin mnem = "sltu";  code = `ALU_PIPE_FN_SLTU;    res = {31'b0, a < b}; end
            4:  begin mnem = "and";   code = `ALU_PIPE_FN_AND;     res = a & b;  end
            5:  begin mnem = "or";    code = `ALU_PIPE_FN_OR;      res = a | b;  end
            6:  begin mnem = "xor";   code = `ALU_PIPE_FN_XOR;     res = a ^ b;  end
            7:  begin mnem = "nor";   code = `ALU_PIPE_FN_NOR;     res = ~(a | b); end
            8:  begin mnem = "sll";   code = `ALU_PIPE_FN_SLL;     res = b << sa; end
            9:  begin mnem = "srl";   code = `ALU_PIPE_FN_SRL;     res = b >> sa; end
            10: begin mnem = "sra";   code = `ALU_PIPE_FN_SRA;     res = $signed(b) >>> sa; end
            11: begin mnem = "sllv";  code = `ALU_PIPE_FN_SLLV;    res = b << a[4:0]; end
            12: begin mnem = "srlv";  code = `ALU_PIPE_FN_SRLV;    res = b >> a[4:0]; end
            13: begin mnem = "srav";  code = `ALU_PIPE_FN_SRAV;
                      res = $signed(b) >>> a[4:0]; end
            14: begin mnem = "addiu"; code = `ALU_PIPE_OPC_ADDIU;  res = a + simm; end
            15: begin mnem = "slti";  code = `ALU_PIPE_OPC_SLTI;
                      res = {31'b0, $signed(a) < $signed(simm)}; end
            16: begin mnem = "sltiu"; code = `ALU_PIPE_OPC_SLTIU;  res = {31'b0, a < simm}; end
            17: begin mnem = "andi";  code = `ALU_PIPE_OPC_ANDI;   res = a & zimm; end
            18: begin mnem = "ori";   code = `ALU_PIPE_OPC_ORI;    res = a | zimm; end
            19: begin mnem = "xori";  code = `ALU_PIPE_OPC_XORI;   res = a ^ zimm; end
            default: begin mnem = "lui"; code = `ALU_PIPE_OPC_LUI; res = {imm, 16'h0000}; end
        endcase
        if (kind < 14) begin
            inst = {`ALU_PIPE_OPC_SPECIAL, rs, rt, rd, sa, code};
            dest = rd;
        end else begin
            inst = {code, rs, rt, imm};
            dest = rt;
        end
        inst_valid = 1'b1;
        if (dest != 5'd0) model_regs[dest] = res;  // program order
        pending.push_back('{cycle + 3, dest != 5'd0, 1'b0, dest, res,
                            $sformatf("%s #%0d", mnem, n)});
    endtask

    task automatic issue_reserved(input int n);
        logic [31:0] w;
        w = $random(seed);
        if (w[0]) begin
            w[31:26] = w[31:26] | 6'h10;  // opcode range with nothing decoded
        end else begin
            w[31:26] = `ALU_PIPE_OPC_SPECIAL;
            w[10:6]  = w[10:6] | 5'd1;    // addu with nonzero sa
            w[5:0]   = `ALU_PIPE_FN_ADDU;
        end
        inst       = w;
        inst_valid = 1'b1;
        pending.push_back('{cycle + 3, 1'b0, 1'b1, 5'd0, 32'd0,
                            $sformatf("reserved #%0d", n)});
    endtask

    always @(negedge clk) begin : wb_check
        wb_exp_t e;
        if (pending.size() > 0 && pending[0].due == cycle) begin
            e = pending.pop_front();
            assert (wb_valid === 1'b1) else begin
                flow_errors++;
                $display("write-back for %s missing at cycle %0d", e.name, cycle);
            end
            if (wb_valid === 1'b1) begin
                check_field(e.name, "wb_ri", {31'b0, e.ri}, {31'b0, wb_ri});
                check_field(e.name, "wb_we", {31'b0, e.we}, {31'b0, wb_we});
                if (!e.ri) begin
                    check_field(e.name, "wb_addr", {27'b0, e.addr}, {27'b0, wb_addr});
                    check_field(e.name, "wb_data", e.data, wb_data);
                end
            end
        end else begin
            assert (wb_valid === 1'b0) else begin
                flow_errors++;
                $display("unexpected write-back at cycle %0d", cycle);
            end
        end
    end

    initial begin : watchdog
        #(CLK_PERIOD * (NUM_INSTS + RESET_CYCLES + 20));
        $display("timeout, the run did not reach its end");
        $display("Some tests failed");
        $finish;
    end

    initial begin : stimulus
        int sel;
        seed         = 4409;
        cycle        = 0;
        value_errors = 0;
        flow_errors  = 0;
        reset        = 1'b1;
        inst_valid   = 1'b1;  // held high through reset, never retired
        inst         = $random(seed);
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        reset      = 1'b0;
        inst_valid = 1'b0;
        for (int n = 0; n < NUM_INSTS; n++) begin
            @(posedge clk);
            #5;
            sel = int'($unsigned($random(seed)) % 100);
            if (sel < 15) begin
                inst_valid = 1'b0;
                inst       = $random(seed);  // bubble with junk on inst
            end else if (sel < 25) begin
                issue_reserved(n);
            end else begin
                issue_kept(n);
            end
        end
        @(posedge clk);
        #5;
        inst_valid = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        assert (pending.size() == 0) else begin
            flow_errors++;
            $display("%0d write-backs never appeared", pending.size());
        end
        $display("errors: %0d value, %0d flow", value_errors, flow_errors);
        if (value_errors == 0 && flow_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- alu_pipe_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "alu_pipe_defines.svh"

module alu_pipe_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          inst_valid,
    input  logic [`ALU_PIPE_XLEN-1:0]     inst,
    output logic                          wb_valid,
    output logic                          wb_we,
    output logic [`ALU_PIPE_RADDR_W-1:0]  wb_addr,
    output logic [`ALU_PIPE_XLEN-1:0]     wb_data,
    output logic                          wb_ri
);

    dec_exe_if de_if ();
    exe_res_if er_if ();
    rf_read_if rf_if ();

    decode_stage u_decode (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .de         (de_if.decode),
        .rf         (rf_if.reader)
    );

    execute_stage u_execute (
        .clk   (clk),
        .reset (reset),
        .de    (de_if.execute),
        .er    (er_if.producer)
    );

    result_stage u_result (
        .clk      (clk),
        .reset    (reset),
        .er       (er_if.consumer),
        .rf       (rf_if.file),
        .wb_valid (wb_valid),
        .wb_we    (wb_we),
        .wb_ri    (wb_ri),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

endmodule

`default_nettype wire

//--- result_stage.sv
`timescale 1ns/1ns
`default_nettype none
`include "alu_pipe_defines.svh"

module result_stage (
    input  logic                          clk,
    input  logic                          reset,
    exe_res_if.consumer                   er,
    rf_read_if.file                       rf,
    output logic                          wb_valid,
    output logic                          wb_we,
    output logic                          wb_ri,
    output logic [`ALU_PIPE_RADDR_W-1:0]  wb_addr,
    output logic [`ALU_PIPE_XLEN-1:0]     wb_data
);

    logic [`ALU_PIPE_XLEN-1:0] regs [`ALU_PIPE_NREGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `ALU_PIPE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (er.we) begin
            regs[er.dest] <= er.data;
        end
    end

    // r0 reads as zero whatever is stored
    assign rf.rdata1 = (rf.raddr1 == '0) ? '0 : regs[rf.raddr1];
    assign rf.rdata2 = (rf.raddr2 == '0) ? '0 : regs[rf.raddr2];

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
            wb_we    <= 1'b0;
            wb_ri    <= 1'b0;
        end else begin
            wb_valid <= er.valid;
            wb_we    <= er.we;
            wb_ri    <= er.ri;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr <= er.dest;
        wb_data <= er.data;  // reported even when not written
    end

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/1ns
`default_nettype none
`include "alu_pipe_defines.svh"

module execute_stage (
    input  logic         clk,
    input  logic         reset,
    dec_exe_if.execute   de,
    exe_res_if.producer  er
);
    import alu_pipe_pkg::*;

    localparam int SHAMT_W = $clog2(`ALU_PIPE_XLEN);

    logic                          valid_r;
    logic                          we_r;
    logic                          ri_r;
    dec_ctrl_t                     ctrl_r;
    logic [`ALU_PIPE_XLEN-1:0]     rs_r;
    logic [`ALU_PIPE_XLEN-1:0]     rt_r;
    logic [`ALU_PIPE_RADDR_W-1:0]  dest_r;
    logic [`ALU_PIPE_XLEN-1:0]     simm;
    logic [`ALU_PIPE_XLEN-1:0]     zimm;
    logic [`ALU_PIPE_XLEN-1:0]     src1;
    logic [`ALU_PIPE_XLEN-1:0]     src2;
    logic [SHAMT_W-1:0]            shamt;
    logic [`ALU_PIPE_XLEN-1:0]     result;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r <= 1'b0;
            we_r    <= 1'b0;
            ri_r    <= 1'b0;
        end else begin
            valid_r <= de.valid;
            we_r    <= de.we;
            ri_r    <= de.ri;
        end
    end

    always_ff @(posedge clk) begin
        ctrl_r <= de.ctrl;
        rs_r   <= de.rs_value;
        rt_r   <= de.rt_value;
        dest_r <= de.dest;
    end

    assign simm  = {{(`ALU_PIPE_XLEN-16){ctrl_r.imm[15]}}, ctrl_r.imm};
    assign zimm  = {{(`ALU_PIPE_XLEN-16){1'b0}}, ctrl_r.imm};
    assign src1  = (ctrl_r.src1_sel == SRC1_SA) ?
                   {{(`ALU_PIPE_XLEN-5){1'b0}}, ctrl_r.sa} : rs_r;
    assign shamt = src1[SHAMT_W-1:0];  // low bits of rs for the v-shifts

    always_comb begin
        case (ctrl_r.src2_sel)
            SRC2_SIMM: src2 = simm;
            SRC2_ZIMM: src2 = zimm;
            default:   src2 = rt_r;
        endcase
    end

    always_comb begin
        case (ctrl_r.alu_op)
            ALU_ADD:  result = src1 + src2;
            ALU_SUB:  result = src1 - src2;
            ALU_SLT:  result = {{(`ALU_PIPE_XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            ALU_SLTU: result = {{(`ALU_PIPE_XLEN-1){1'b0}}, src1 < src2};
            ALU_AND:  result = src1 & src2;
            ALU_NOR:  result = ~(src1 | src2);
            ALU_OR:   result = src1 | src2;
            ALU_XOR:  result = src1 ^ src2;
            ALU_SLL:  result = src2 << shamt;
            ALU_SRL:  result = src2 >> shamt;
            ALU_SRA:  result = $signed(src2) >>> shamt;
            ALU_LUI:  result = {src2[15:0], 16'b0};
            default:  result = '0;
        endcase
    end

    assign er.valid = valid_r;
    assign er.we    = we_r;
    assign er.dest  = dest_r;
    assign er.data  = result;
    assign er.ri    = ri_r;

    // same result seen by decode
    assign de.fwd_valid = valid_r;
    assign de.fwd_we    = we_r;
    assign de.fwd_dest  = dest_r;
    assign de.fwd_data  = result;

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/1ns
`default_nettype none
`include "alu_pipe_defines.svh"

module decode_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       inst_valid,
    input  logic [`ALU_PIPE_XLEN-1:0]  inst,
    dec_exe_if.decode                  de,
    rf_read_if.reader                  rf
);
    import alu_pipe_pkg::*;

    logic                                         valid_r;
    logic [`ALU_PIPE_XLEN-1:0]                    inst_r;
    logic [`ALU_PIPE_OP_HI-`ALU_PIPE_OP_LO:0]     op;
    logic [`ALU_PIPE_FUNC_HI-`ALU_PIPE_FUNC_LO:0] func;
    logic [`ALU_PIPE_RADDR_W-1:0]                 rs;
    logic [`ALU_PIPE_RADDR_W-1:0]                 rt;
    logic [`ALU_PIPE_RADDR_W-1:0]                 rd;
    logic [`ALU_PIPE_SA_HI-`ALU_PIPE_SA_LO:0]     sa;
    logic [`ALU_PIPE_RADDR_W-1:0]                 dest;
    alu_op_t                                      r_op;
    alu_op_t                                      i_op;
    logic                                         r_known;
    logic                                         i_known;
    logic                                         r_shift_imm;
    logic                                         r_match;
    logic                                         i_match;
    logic                                         i_zext;
    logic                                         ri;
    logic                                         fwd_rs;
    logic                                         fwd_rt;
    dec_ctrl_t                                    ctrl;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r <= 1'b0;
        end else begin
            valid_r <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            inst_r <= inst;
        end
    end

    assign op   = inst_r[`ALU_PIPE_OP_HI:`ALU_PIPE_OP_LO];
    assign rs   = inst_r[`ALU_PIPE_RS_HI:`ALU_PIPE_RS_LO];
    assign rt   = inst_r[`ALU_PIPE_RT_HI:`ALU_PIPE_RT_LO];
    assign rd   = inst_r[`ALU_PIPE_RD_HI:`ALU_PIPE_RD_LO];
    assign sa   = inst_r[`ALU_PIPE_SA_HI:`ALU_PIPE_SA_LO];
    assign func = inst_r[`ALU_PIPE_FUNC_HI:`ALU_PIPE_FUNC_LO];

    always_comb begin
        r_op    = ALU_ADD;
        r_known = 1'b1;
        case (func)
            `ALU_PIPE_FN_ADDU: r_op = ALU_ADD;
            `ALU_PIPE_FN_SUBU: r_op = ALU_SUB;
            `ALU_PIPE_FN_SLT:  r_op = ALU_SLT;
            `ALU_PIPE_FN_SLTU: r_op = ALU_SLTU;
            `ALU_PIPE_FN_AND:  r_op = ALU_AND;
            `ALU_PIPE_FN_OR:   r_op = ALU_OR;
            `ALU_PIPE_FN_XOR:  r_op = ALU_XOR;
            `ALU_PIPE_FN_NOR:  r_op = ALU_NOR;
            `ALU_PIPE_FN_SLL:  r_op = ALU_SLL;
            `ALU_PIPE_FN_SRL:  r_op = ALU_SRL;
            `ALU_PIPE_FN_SRA:  r_op = ALU_SRA;
            `ALU_PIPE_FN_SLLV: r_op = ALU_SLL;
            `ALU_PIPE_FN_SRLV: r_op = ALU_SRL;
            `ALU_PIPE_FN_SRAV: r_op = ALU_SRA;
            default:           r_known = 1'b0;
        endcase
    end

    assign r_shift_imm = (func == `ALU_PIPE_FN_SLL) || (func == `ALU_PIPE_FN_SRL) ||
                         (func == `ALU_PIPE_FN_SRA);
    // shifts by sa need rs zero, the rest need sa zero
    assign r_match = (op == `ALU_PIPE_OPC_SPECIAL) && r_known &&
                     (r_shift_imm ? (rs == '0) : (sa == '0));

    always_comb begin
        i_op    = ALU_ADD;
        i_known = 1'b1;
        case (op)
            `ALU_PIPE_OPC_ADDIU: i_op = ALU_ADD;
            `ALU_PIPE_OPC_SLTI:  i_op = ALU_SLT;
            `ALU_PIPE_OPC_SLTIU: i_op = ALU_SLTU;
            `ALU_PIPE_OPC_ANDI:  i_op = ALU_AND;
            `ALU_PIPE_OPC_ORI:   i_op = ALU_OR;
            `ALU_PIPE_OPC_XORI:  i_op = ALU_XOR;
            `ALU_PIPE_OPC_LUI:   i_op = ALU_LUI;
            default:             i_known = 1'b0;
        endcase
    end

    assign i_zext  = (op == `ALU_PIPE_OPC_ANDI) || (op == `ALU_PIPE_OPC_ORI) ||
                     (op == `ALU_PIPE_OPC_XORI) || (op == `ALU_PIPE_OPC_LUI);
    assign i_match = i_known && ((op != `ALU_PIPE_OPC_LUI) || (rs == '0));

    always_comb begin
        ctrl.alu_op   = r_match ? r_op : i_op;
        ctrl.src1_sel = (r_match && r_shift_imm) ? SRC1_SA : SRC1_RS;
        ctrl.src2_sel = r_match ? SRC2_RT : (i_zext ? SRC2_ZIMM : SRC2_SIMM);
        ctrl.imm      = inst_r[`ALU_PIPE_IMM_HI:`ALU_PIPE_IMM_LO];
        ctrl.sa       = sa;
    end

    assign dest = i_match ? rt : rd;
    assign ri   = valid_r && !(r_match || i_match);

    assign rf.raddr1 = rs;
    assign rf.raddr2 = rt;

    // bypass from the instruction one stage ahead
    assign fwd_rs = de.fwd_valid && de.fwd_we && (de.fwd_dest == rs);
    assign fwd_rt = de.fwd_valid && de.fwd_we && (de.fwd_dest == rt);

    assign de.valid    = valid_r;
    assign de.ctrl     = ctrl;
    assign de.rs_value = fwd_rs ? de.fwd_data : rf.rdata1;
    assign de.rt_value = fwd_rt ? de.fwd_data : rf.rdata2;
    assign de.dest     = dest;
    assign de.we       = valid_r && !ri && (dest != '0);  // r0 never written
    assign de.ri       = ri;

endmodule

`default_nettype wire

//--- pipe_ifs.sv
`timescale 1ns/1ns
`default_nettype none
`include "alu_pipe_defines.svh"

interface dec_exe_if;
    import alu_pipe_pkg::*;

    logic                          valid;
    dec_ctrl_t                     ctrl;
    logic [`ALU_PIPE_XLEN-1:0]     rs_value;
    logic [`ALU_PIPE_XLEN-1:0]     rt_value;
    logic [`ALU_PIPE_RADDR_W-1:0]  dest;
    logic                          we;
    logic                          ri;
    // back from execute for forwarding
    logic                          fwd_valid;
    logic                          fwd_we;
    logic [`ALU_PIPE_RADDR_W-1:0]  fwd_dest;
    logic [`ALU_PIPE_XLEN-1:0]     fwd_data;

    modport decode (
        output valid, ctrl, rs_value, rt_value, dest, we, ri,
        input  fwd_valid, fwd_we, fwd_dest, fwd_data
    );
    modport execute (
        input  valid, ctrl, rs_value, rt_value, dest, we, ri,
        output fwd_valid, fwd_we, fwd_dest, fwd_data
    );
endinterface

interface exe_res_if;
    logic                          valid;
    logic                          we;
    logic [`ALU_PIPE_RADDR_W-1:0]  dest;
    logic [`ALU_PIPE_XLEN-1:0]     data;
    logic                          ri;

    modport producer (output valid, we, dest, data, ri);
    modport consumer (input  valid, we, dest, data, ri);
endinterface

interface rf_read_if;
    logic [`ALU_PIPE_RADDR_W-1:0]  raddr1;
    logic [`ALU_PIPE_RADDR_W-1:0]  raddr2;
    logic [`ALU_PIPE_XLEN-1:0]     rdata1;
    logic [`ALU_PIPE_XLEN-1:0]     rdata2;

    modport reader (output raddr1, raddr2, input  rdata1, rdata2);
    modport file   (input  raddr1, raddr2, output rdata1, rdata2);
endinterface

`default_nettype wire

//--- alu_pipe_pkg.sv
`default_nettype none

package alu_pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_t;

    typedef enum logic {
        SRC1_RS = 1'b0,
        SRC1_SA = 1'b1   // immediate shifts
    } src1_sel_t;

    typedef enum logic [1:0] {
        SRC2_RT   = 2'd0,
        SRC2_SIMM = 2'd1,
        SRC2_ZIMM = 2'd2
    } src2_sel_t;

    // everything execute needs besides the register values
    typedef struct packed {
        alu_op_t    alu_op;
        src1_sel_t  src1_sel;
        src2_sel_t  src2_sel;
        logic [15:0] imm;
        logic [4:0]  sa;
    } dec_ctrl_t;

endpackage

`default_nettype wire

//--- alu_pipe_defines.svh
`ifndef ALU_PIPE_DEFINES_SVH
`define ALU_PIPE_DEFINES_SVH

`define ALU_PIPE_XLEN        32
`define ALU_PIPE_NREGS       32
`define ALU_PIPE_RADDR_W     5

// instruction fields
`define ALU_PIPE_OP_HI       31
`define ALU_PIPE_OP_LO       26
`define ALU_PIPE_RS_HI       25
`define ALU_PIPE_RS_LO       21
`define ALU_PIPE_RT_HI       20
`define ALU_PIPE_RT_LO       16
`define ALU_PIPE_RD_HI       15
`define ALU_PIPE_RD_LO       11
`define ALU_PIPE_SA_HI       10
`define ALU_PIPE_SA_LO       6
`define ALU_PIPE_FUNC_HI     5
`define ALU_PIPE_FUNC_LO     0
`define ALU_PIPE_IMM_HI      15
`define ALU_PIPE_IMM_LO      0

`define ALU_PIPE_OPC_SPECIAL 6'h00  // r-type, func selects the op
`define ALU_PIPE_OPC_ADDIU   6'h09
`define ALU_PIPE_OPC_SLTI    6'h0a
`define ALU_PIPE_OPC_SLTIU   6'h0b
`define ALU_PIPE_OPC_ANDI    6'h0c
`define ALU_PIPE_OPC_ORI     6'h0d
`define ALU_PIPE_OPC_XORI    6'h0e
`define ALU_PIPE_OPC_LUI     6'h0f

`define ALU_PIPE_FN_SLL      6'h00
`define ALU_PIPE_FN_SRL      6'h02
`define ALU_PIPE_FN_SRA      6'h03
`define ALU_PIPE_FN_SLLV     6'h04
`define ALU_PIPE_FN_SRLV     6'h06
`define ALU_PIPE_FN_SRAV     6'h07
`define ALU_PIPE_FN_ADDU     6'h21
`define ALU_PIPE_FN_SUBU     6'h23
`define ALU_PIPE_FN_AND      6'h24
`define ALU_PIPE_FN_OR       6'h25
`define ALU_PIPE_FN_XOR      6'h26
`define ALU_PIPE_FN_NOR      6'h27
`define ALU_PIPE_FN_SLT      6'h2a
`define ALU_PIPE_FN_SLTU     6'h2b

`endif
